//--- Bender.yml
package:
  name: rv_core

sources:
  - source/rv_core_pkg.sv
  - source/regfile.sv
  - source/fetch_stage.sv
  - source/decode_stage.sv
  - source/exec_stage.sv
  - source/writeback_stage.sv
  - source/rv_core_top.sv
  - target: simulation
    files:
      - verification/rv_core_tb.sv

//--- source/decode_stage.sv
// register reads rely on fetch holding the instruction stable while its req is high
`timescale 1ns/1ps

module decode_stage (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_fetched_req,
  output logic                              o_fetched_ack,
  input  logic [rv_core_pkg::XLEN-1:0]      i_pc,
  input  logic [rv_core_pkg::INST_W-1:0]    i_inst,
  output logic [rv_core_pkg::REG_IDX_W-1:0] o_rs1_idx,
  output logic [rv_core_pkg::REG_IDX_W-1:0] o_rs2_idx,
  input  logic [rv_core_pkg::XLEN-1:0]      i_rs1_data,
  input  logic [rv_core_pkg::XLEN-1:0]      i_rs2_data,
  output logic                              o_decoded_req,
  input  logic                              i_decoded_ack,
  output rv_core_pkg::kind_e                o_kind,
  output rv_core_pkg::alu_op_e              o_alu_op,
  output logic [rv_core_pkg::XLEN-1:0]      o_op1,
  output logic [rv_core_pkg::XLEN-1:0]      o_op2,
  output logic [rv_core_pkg::XLEN-1:0]      o_imm,
  output logic [rv_core_pkg::XLEN-1:0]      o_pc,
  output logic [rv_core_pkg::REG_IDX_W-1:0] o_rd,
  output logic                              o_rd_wen
);

  import rv_core_pkg::*;

  logic [2:0]      funct3;
  logic            is_putch;
  logic [XLEN-1:0] imm_i, imm_b, imm_j, imm_u;
  kind_e           d_kind;
  alu_op_e         d_alu_op;
  logic [XLEN-1:0] d_op2, d_imm;
  logic            d_rd_wen;
  logic            take;

  assign funct3   = i_inst[14:12];
  assign is_putch = (i_inst == PUTCH_INST);

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};

  assign o_rs1_idx = is_putch ? PUTCH_REG : i_inst[19:15];
  assign o_rs2_idx = i_inst[24:20];

  always_comb begin
    // unknown encodings fall through as a harmless add
    d_kind   = K_ALU;
    d_alu_op = ALU_ADD;
    d_op2    = i_rs2_data;
    d_imm    = imm_i;
    d_rd_wen = 1'b0;
    case (opcode_e'(i_inst[6:0]))
      OPC_OP_IMM: begin
        d_op2    = imm_i;
        d_rd_wen = 1'b1;
        case (funct3)
          3'b000:  d_alu_op = ALU_ADD;
          3'b010:  d_alu_op = ALU_SLT;
          3'b100:  d_alu_op = ALU_XOR;
          3'b110:  d_alu_op = ALU_OR;
          3'b111:  d_alu_op = ALU_AND;
          default: d_rd_wen = 1'b0;
        endcase
      end
      OPC_OP: begin
        d_rd_wen = 1'b1;
        case (funct3)
          3'b000:  d_alu_op = i_inst[30] ? ALU_SUB : ALU_ADD;
          3'b010:  d_alu_op = ALU_SLT;
          3'b100:  d_alu_op = ALU_XOR;
          3'b110:  d_alu_op = ALU_OR;
          3'b111:  d_alu_op = ALU_AND;
          default: d_rd_wen = 1'b0;
        endcase
      end
      OPC_LUI: begin
        d_alu_op = ALU_PASS_B;
        d_op2    = imm_u;
        d_rd_wen = 1'b1;
      end
      OPC_BRANCH: begin
        d_kind   = K_BRANCH;
        d_alu_op = (funct3 == 3'b000) ? ALU_EQ : ALU_NE;
        d_imm    = imm_b;
      end
      OPC_JAL: begin
        d_kind   = K_JAL;
        d_imm    = imm_j;
        d_rd_wen = 1'b1;
      end
      OPC_PUTCH: if (is_putch) d_kind = K_PUTCH;
      default: ;
    endcase
  end

  assign o_fetched_ack = ~o_decoded_req;
  assign take          = i_fetched_req & o_fetched_ack;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_decoded_req <= 1'b0;
    end else if (take) begin
      o_decoded_req <= 1'b1;
    end else if (i_decoded_ack) begin
      o_decoded_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      o_kind   <= d_kind;
      o_alu_op <= d_alu_op;
      o_op1    <= i_rs1_data;
      o_op2    <= d_op2;
      o_imm    <= d_imm;
      o_pc     <= i_pc;
      o_rd     <= i_inst[11:7];
      o_rd_wen <= d_rd_wen;
    end
  end

endmodule

//--- source/exec_stage.sv
// branch and jal targets are not checked for alignment
`timescale 1ns/1ps

module exec_stage (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_decoded_req,
  output logic                              o_decoded_ack,
  input  rv_core_pkg::kind_e                i_kind,
  input  rv_core_pkg::alu_op_e              i_alu_op,
  input  logic [rv_core_pkg::XLEN-1:0]      i_op1,
  input  logic [rv_core_pkg::XLEN-1:0]      i_op2,
  input  logic [rv_core_pkg::XLEN-1:0]      i_imm,
  input  logic [rv_core_pkg::XLEN-1:0]      i_pc,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] i_rd,
  input  logic                              i_rd_wen,
  output logic                              o_executed_req,
  input  logic                              i_executed_ack,
  output rv_core_pkg::kind_e                o_kind,
  output logic [rv_core_pkg::XLEN-1:0]      o_result,
  output logic [rv_core_pkg::XLEN-1:0]      o_next_pc,
  output logic [rv_core_pkg::REG_IDX_W-1:0] o_rd,
  output logic                              o_rd_wen
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] pc_plus4, pc_target;
  logic [XLEN-1:0] e_result, e_next_pc;
  logic            take;

  ////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (i_alu_op)
      ALU_ADD:    alu_out = i_op1 + i_op2;
      ALU_SUB:    alu_out = i_op1 - i_op2;
      ALU_AND:    alu_out = i_op1 & i_op2;
      ALU_OR:     alu_out = i_op1 | i_op2;
      ALU_XOR:    alu_out = i_op1 ^ i_op2;
      ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(i_op1) < $signed(i_op2)};
      ALU_PASS_B: alu_out = i_op2;
      ALU_EQ:     alu_out = {{(XLEN-1){1'b0}}, i_op1 == i_op2};
      ALU_NE:     alu_out = {{(XLEN-1){1'b0}}, i_op1 != i_op2};
      default:    alu_out = '0;
    endcase
  end

  assign pc_plus4  = i_pc + XLEN'(4);
  assign pc_target = i_pc + i_imm;

  always_comb begin
    e_result  = alu_out;
    e_next_pc = pc_plus4;
    case (i_kind)
      // bit 0 of the compare decides the branch
      K_BRANCH: e_next_pc = alu_out[0] ? pc_target : pc_plus4;
      K_JAL: begin
        e_result  = pc_plus4;
        e_next_pc = pc_target;
      end
      K_PUTCH:  e_result = i_op1;
      default:  ;
    endcase
  end

  assign o_decoded_ack = ~o_executed_req;
  assign take          = i_decoded_req & o_decoded_ack;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_executed_req <= 1'b0;
    end else if (take) begin
      o_executed_req <= 1'b1;
    end else if (i_executed_ack) begin
      o_executed_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      o_kind    <= i_kind;
      o_result  <= e_result;
      o_next_pc <= e_next_pc;
      o_rd      <= i_rd;
      o_rd_wen  <= i_rd_wen;
    end
  end

endmodule

//--- source/fetch_stage.sv
// retire must arrive only while idle; instruction word is sampled in the ack cycle
`timescale 1ns/1ps

module fetch_stage (
  input  logic                           clk,
  input  logic                           i_arst_n,
  input  logic                           i_retire,
  input  logic [rv_core_pkg::XLEN-1:0]   i_retire_pc,
  output logic                           o_imem_req,
  output logic [rv_core_pkg::XLEN-1:0]   o_imem_addr,
  input  logic                           i_imem_ack,
  input  logic [rv_core_pkg::INST_W-1:0] i_imem_rdata,
  output logic                           o_fetched_req,
  input  logic                           i_fetched_ack,
  output logic [rv_core_pkg::XLEN-1:0]   o_pc,
  output logic [rv_core_pkg::INST_W-1:0] o_inst
);

  import rv_core_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    HOLD
  } state_e;

  state_e            state;
  logic              r_boot;
  logic [XLEN-1:0]   r_pc;
  logic [INST_W-1:0] r_inst;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state  <= IDLE;
      r_boot <= 1'b1;
      r_pc   <= PC_RESET;
    end else begin
      case (state)
        IDLE: begin
          // first request after reset needs no retire
          if (r_boot) begin
            r_boot <= 1'b0;
            state  <= REQ;
          end else if (i_retire) begin
            r_pc  <= i_retire_pc;
            state <= REQ;
          end
        end
        REQ:     if (i_imem_ack) state <= HOLD;
        HOLD:    if (i_fetched_ack) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == REQ && i_imem_ack) begin
      r_inst <= i_imem_rdata;
    end
  end

  assign o_imem_req    = (state == REQ);
  assign o_imem_addr   = r_pc;
  assign o_fetched_req = (state == HOLD);
  assign o_pc          = r_pc;
  assign o_inst        = r_inst;

endmodule

//--- source/regfile.sv
// no write-to-read bypass; reads see a write only after the clock edge
`timescale 1ns/1ps

module regfile (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] i_rs1_idx,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] i_rs2_idx,
  output logic [rv_core_pkg::XLEN-1:0]      o_rs1_data,
  output logic [rv_core_pkg::XLEN-1:0]      o_rs2_data,
  input  logic                              i_wen,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] i_rd,
  input  logic [rv_core_pkg::XLEN-1:0]      i_wdata
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_rd != '0) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // x0 hardwired
  assign o_rs1_data = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
  assign o_rs2_data = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

endmodule

//--- source/rv_core_pkg.sv
// rv32 integer subset only: no loads, stores, csrs or interrupts; one instruction in flight
package rv_core_pkg;

  ////////////////////////////////////////////////////////////
  // widths and fixed values
  ////////////////////////////////////////////////////////////
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;
  localparam int INST_W    = 32;

  localparam logic [XLEN-1:0]      PC_RESET   = 32'h0000_0000;
  localparam logic [INST_W-1:0]    PUTCH_INST = 32'h0000_007b;
  // a0 holds the character
  localparam logic [REG_IDX_W-1:0] PUTCH_REG  = 5'd10;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b001_0011,
    OPC_OP     = 7'b011_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_JAL    = 7'b110_1111,
    OPC_PUTCH  = 7'b111_1011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_PASS_B = 4'd6,
    ALU_EQ     = 4'd7,
    ALU_NE     = 4'd8
  } alu_op_e;

  // instruction class carried down to writeback
  typedef enum logic [1:0] {
    K_ALU    = 2'd0,
    K_BRANCH = 2'd1,
    K_JAL    = 2'd2,
    K_PUTCH  = 2'd3
  } kind_e;

endpackage

//--- source/rv_core_top.sv
// instruction port only, no data memory; putch is the single output channel
`timescale 1ns/1ps

module rv_core_top (
  input  logic                           clk,
  input  logic                           i_arst_n,
  output logic                           o_imem_req,
  output logic [rv_core_pkg::XLEN-1:0]   o_imem_addr,
  input  logic                           i_imem_ack,
  input  logic [rv_core_pkg::INST_W-1:0] i_imem_rdata,
  output logic                           o_putch_valid,
  output logic [7:0]                     o_putch_data
);

  import rv_core_pkg::*;

  // stage handshakes
  logic fetched_req, fetched_ack;
  logic decoded_req, decoded_ack;
  logic executed_req, executed_ack;

  logic [XLEN-1:0]      f_pc;
  logic [INST_W-1:0]    f_inst;
  logic [REG_IDX_W-1:0] rs1_idx, rs2_idx;
  logic [XLEN-1:0]      rs1_data, rs2_data;

  kind_e                d_kind;
  alu_op_e              d_alu_op;
  logic [XLEN-1:0]      d_op1, d_op2, d_imm, d_pc;
  logic [REG_IDX_W-1:0] d_rd;
  logic                 d_rd_wen;

  kind_e                e_kind;
  logic [XLEN-1:0]      e_result, e_next_pc;
  logic [REG_IDX_W-1:0] e_rd;
  logic                 e_rd_wen;

  logic                 rf_wen;
  logic [REG_IDX_W-1:0] rf_rd;
  logic [XLEN-1:0]      rf_wdata;
  logic                 retire;
  logic [XLEN-1:0]      retire_pc;

  ////////////////////////////////////////////////////////////
  // stage chain
  ////////////////////////////////////////////////////////////
  fetch_stage u_fetch (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_retire      (retire),
    .i_retire_pc   (retire_pc),
    .o_imem_req    (o_imem_req),
    .o_imem_addr   (o_imem_addr),
    .i_imem_ack    (i_imem_ack),
    .i_imem_rdata  (i_imem_rdata),
    .o_fetched_req (fetched_req),
    .i_fetched_ack (fetched_ack),
    .o_pc          (f_pc),
    .o_inst        (f_inst)
  );

  decode_stage u_decode (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_fetched_req (fetched_req),
    .o_fetched_ack (fetched_ack),
    .i_pc          (f_pc),
    .i_inst        (f_inst),
    .o_rs1_idx     (rs1_idx),
    .o_rs2_idx     (rs2_idx),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .o_decoded_req (decoded_req),
    .i_decoded_ack (decoded_ack),
    .o_kind        (d_kind),
    .o_alu_op      (d_alu_op),
    .o_op1         (d_op1),
    .o_op2         (d_op2),
    .o_imm         (d_imm),
    .o_pc          (d_pc),
    .o_rd          (d_rd),
    .o_rd_wen      (d_rd_wen)
  );

  exec_stage u_exec (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_decoded_req  (decoded_req),
    .o_decoded_ack  (decoded_ack),
    .i_kind         (d_kind),
    .i_alu_op       (d_alu_op),
    .i_op1          (d_op1),
    .i_op2          (d_op2),
    .i_imm          (d_imm),
    .i_pc           (d_pc),
    .i_rd           (d_rd),
    .i_rd_wen       (d_rd_wen),
    .o_executed_req (executed_req),
    .i_executed_ack (executed_ack),
    .o_kind         (e_kind),
    .o_result       (e_result),
    .o_next_pc      (e_next_pc),
    .o_rd           (e_rd),
    .o_rd_wen       (e_rd_wen)
  );

  writeback_stage u_writeback (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_executed_req (executed_req),
    .o_executed_ack (executed_ack),
    .i_kind         (e_kind),
    .i_result       (e_result),
    .i_next_pc      (e_next_pc),
    .i_rd           (e_rd),
    .i_rd_wen       (e_rd_wen),
    .o_rf_wen       (rf_wen),
    .o_rf_rd        (rf_rd),
    .o_rf_wdata     (rf_wdata),
    .o_putch_valid  (o_putch_valid),
    .o_putch_data   (o_putch_data),
    .o_retire       (retire),
    .o_retire_pc    (retire_pc)
  );

  regfile u_regfile (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_rs1_idx  (rs1_idx),
    .i_rs2_idx  (rs2_idx),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wen      (rf_wen),
    .i_rd       (rf_rd),
    .i_wdata    (rf_wdata)
  );

endmodule

//--- source/writeback_stage.sv
// busy for one cycle per item; rf write, putch and retire all land in that cycle
`timescale 1ns/1ps

module writeback_stage (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_executed_req,
  output logic                              o_executed_ack,
  input  rv_core_pkg::kind_e                i_kind,
  input  logic [rv_core_pkg::XLEN-1:0]      i_result,
  input  logic [rv_core_pkg::XLEN-1:0]      i_next_pc,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] i_rd,
  input  logic                              i_rd_wen,
  output logic                              o_rf_wen,
  output logic [rv_core_pkg::REG_IDX_W-1:0] o_rf_rd,
  output logic [rv_core_pkg::XLEN-1:0]      o_rf_wdata,
  output logic                              o_putch_valid,
  output logic [7:0]                        o_putch_data,
  output logic                              o_retire,
  output logic [rv_core_pkg::XLEN-1:0]      o_retire_pc
);

  import rv_core_pkg::*;

  logic               r_valid;
  kind_e              r_kind;
  logic [XLEN-1:0]    r_result;
  logic [XLEN-1:0]    r_next_pc;
  logic [REG_IDX_W-1:0] r_rd;
  logic               r_rd_wen;
  logic               take;

  assign o_executed_ack = ~r_valid;
  assign take           = i_executed_req & o_executed_ack;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      r_kind    <= i_kind;
      r_result  <= i_result;
      r_next_pc <= i_next_pc;
      r_rd      <= i_rd;
      r_rd_wen  <= i_rd_wen;
    end
  end

  assign o_rf_wen      = r_valid & r_rd_wen;
  assign o_rf_rd       = r_rd;
  assign o_rf_wdata    = r_result;
  assign o_putch_valid = r_valid & (r_kind == K_PUTCH);
  assign o_putch_data  = r_result[7:0];
  assign o_retire      = r_valid;
  assign o_retire_pc   = r_next_pc;

endmodule

//--- tb.f
source/rv_core_pkg.sv
source/regfile.sv
source/fetch_stage.sv
source/decode_stage.sv
source/exec_stage.sv
source/writeback_stage.sv
source/rv_core_top.sv
verification/rv_core_tb.sv

//--- verification/program_cases.txt
# case <name> <step limit>, then program words in hex from address 0
# expect, then the putch bytes in hex in print order
case imm_ops 40
04100513 7b   # addi a0,x0,0x41
00354513 7b   # xori a0,a0,0x03
00c56513 7b   # ori a0,a0,0x0c
0f057513 7b   # andi a0,a0,0xf0
04152513 7b   # slti a0,a0,0x41
ffe00513 7b   # addi a0,x0,-2
12345537 06750513 7b   # lui a0,0x12345 then addi 0x67
7ff52513 7b   # slti a0,a0,0x7ff is 0 with the upper bits set
0000006f
expect 41 42 4e 40 01 fe 67 00

case reg_ops 48
06400293 ffb00313   # t0 = 100, t1 = -5
00628533 7b 40628533 7b 0062f533 7b 0062e533 7b   # add sub and or
0062c533 7b 0062a533 7b 00532533 7b   # xor, slt both ways
40500533 7b   # sub a0,x0,t0
800003b7 fff38393 00538533 7b   # 0x7fffffff + 100 wraps
00052533 7b   # slt a0,a0,x0
0000006f
expect 5f 69 60 ff 9f 00 01 9c 63 01

case x0_zero 20
00500013 12345037   # writes to x0
00700293 00528033 00000533 7b 00500533 7b
0000006f
expect 00 07

case branches 50
03100513 00300293 00028463 7b   # beq not taken
00029463 7b   # bne taken skips this putch
03200513 7b
03028513 7b fff28293 fe029ae3   # countdown from 3
00028463 7b 02100513 7b
0000006f
expect 31 32 33 32 31 21

case jal_link 20
008000ef 7b 00008533 7b   # jal ra,8 then print ra
00c0056f 7b 7b 7b   # jal a0,12 lands on the last putch
0000006f
expect 04 14

//--- verification/rv_core_tb.sv
// reads verification/program_cases.txt relative to the project root; programs end in a self-loop
`timescale 1ns/1ps

module rv_core_tb;

  import rv_core_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_STEP = 8;

  logic              clk;
  logic              i_arst_n;
  logic              o_imem_req;
  logic [XLEN-1:0]   o_imem_addr;
  logic              i_imem_ack;
  logic [INST_W-1:0] i_imem_rdata;
  logic              o_putch_valid;
  logic [7:0]        o_putch_data;

  // case table with words and bytes flattened
  string             case_name[$];
  int                case_steps[$];
  int                word_base[$];
  int                word_cnt[$];
  int                byte_base[$];
  int                byte_cnt[$];
  logic [INST_W-1:0] prog_words[$];
  logic [7:0]        exp_bytes[$];

  int cycle_count = 0;
  int cycle_limit = 0;
  int pass_cnt    = 0;
  int fail_cnt    = 0;
  bit load_ok;

  rv_core_top dut (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .o_imem_req    (o_imem_req),
    .o_imem_addr   (o_imem_addr),
    .i_imem_ack    (i_imem_ack),
    .i_imem_rdata  (i_imem_rdata),
    .o_putch_valid (o_putch_valid),
    .o_putch_data  (o_putch_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // whole-run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic bit known_opcode(input logic [INST_W-1:0] w);
    case (w[6:0])
      OPC_OP_IMM, OPC_OP, OPC_LUI, OPC_BRANCH, OPC_JAL, OPC_PUTCH: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // case file reader
  ////////////////////////////////////////////////////////////
  task automatic load_cases(output bit ok);
    int          fd;
    int          rc;
    int          steps;
    string       tok;
    string       rest;
    string       name;
    logic [31:0] val;
    bit          in_expect;
    bit          bad;
    begin
      bad       = 1'b0;
      in_expect = 1'b0;
      fd = $fopen("verification/program_cases.txt", "r");
      if (fd == 0) begin
        bad = 1'b1;
      end else begin
        while ($fscanf(fd, "%s", tok) == 1) begin
          if (tok.substr(0, 0) == "#") begin
            rc = $fgets(rest, fd);
          end else if (tok == "case") begin
            rc = $fscanf(fd, "%s %d", name, steps);
            if (rc != 2) begin
              $display("a case header in the case file lacks its name or step limit");
              bad = 1'b1;
            end
            case_name.push_back(name);
            case_steps.push_back(steps);
            word_base.push_back(prog_words.size());
            word_cnt.push_back(0);
            byte_base.push_back(exp_bytes.size());
            byte_cnt.push_back(0);
            in_expect = 1'b0;
          end else if (tok == "expect") begin
            in_expect = 1'b1;
          end else if (case_name.size() == 0 || $sscanf(tok, "%h", val) != 1) begin
            bad = 1'b1;
          end else if (in_expect) begin
            exp_bytes.push_back(val[7:0]);
            byte_cnt[byte_cnt.size()-1] += 1;
          end else begin
            if (!known_opcode(val)) begin
              $display("case %0s holds word %08h with an unknown opcode", name, val);
              bad = 1'b1;
            end
            prog_words.push_back(val);
            word_cnt[word_cnt.size()-1] += 1;
          end
        end
        $fclose(fd);
      end
      ok = !bad && case_name.size() > 0;
    end
  endtask

  task automatic apply_reset(inout int errs);
    begin
      i_arst_n     = 1'b0;
      i_imem_ack   = 1'b0;
      i_imem_rdata = '0;
      repeat (RESET_CYCLES) begin
        @(posedge clk);
        #1;
        if (o_putch_valid !== 1'b0) begin
          $display("ERR %0d ns: o_putch_valid expected 0, seen %b", $time, o_putch_valid);
          errs++;
        end
      end
      i_arst_n = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one case with instruction memory model and putch checks
  ////////////////////////////////////////////////////////////
  task automatic run_case(input int c);
    int              got;
    int              fetches;
    int              errs;
    int              wait_cnt;
    int              idx;
    bit              done;
    bit              req_seen;
    logic [XLEN-1:0] addr_seen;
    logic [7:0]      exp_byte;
    begin
      got      = 0;
      fetches  = 0;
      errs     = 0;
      done     = 1'b0;
      wait_cnt = $urandom % 4;
      apply_reset(errs);
      while (!done) begin
        @(posedge clk);
        req_seen  = o_imem_req;
        addr_seen = o_imem_addr;
        if (o_putch_valid) begin
          exp_byte = exp_bytes[byte_base[c] + got];
          if (o_putch_data !== exp_byte) begin
            $display("ERR %0d ns: o_putch_data expected %02h, seen %02h",
                     $time, exp_byte, o_putch_data);
            errs++;
          end
          got++;
          done = (got == byte_cnt[c]);
        end
        #1;
        if (i_imem_ack) begin
          i_imem_ack = 1'b0;
        end else if (req_seen && !done) begin
          if (wait_cnt > 0) begin
            wait_cnt--;
          end else begin
            fetches++;
            // first fetch after reset
            if (fetches == 1 && addr_seen !== PC_RESET) begin
              $display("ERR %0d ns: o_imem_addr expected %08h, seen %08h",
                       $time, PC_RESET, addr_seen);
              errs++;
            end
            idx = addr_seen[XLEN-1:2];
            if (addr_seen[1:0] != 2'b00 || idx >= word_cnt[c]) begin
              $display("case %0s fetched address %08h outside its program",
                       case_name[c], addr_seen);
              errs++;
              done = 1'b1;
            end else if (fetches > case_steps[c]) begin
              $display("case %0s ran past its limit of %0d steps", case_name[c], case_steps[c]);
              errs++;
              done = 1'b1;
            end else begin
              i_imem_rdata = prog_words[word_base[c] + idx];
              i_imem_ack   = 1'b1;
              wait_cnt     = $urandom % 4;
            end
          end
        end
      end
      if (errs == 0) begin
        pass_cnt++;
        $display("case %0s passed: %0d bytes, %0d fetches", case_name[c], got, fetches);
      end else begin
        fail_cnt++;
        $display("case %0s failed: %0d errors", case_name[c], errs);
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    i_arst_n     = 1'b0;
    i_imem_ack   = 1'b0;
    i_imem_rdata = '0;
    void'($urandom(77));
    load_cases(load_ok);
    if (!load_ok) begin
      $display("the case file could not be read or holds no valid cases");
      $display("Test FAILED");
      $finish;
    end else begin
      foreach (case_steps[i]) begin
        cycle_limit += case_steps[i] * CYCLES_PER_STEP;
      end
      for (int c = 0; c < case_name.size(); c++) begin
        run_case(c);
      end
      $display("cases run %0d, passed %0d, failed %0d", case_name.size(), pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

endmodule
